// ==== sim.f ====
source/rv_core_pkg.sv
source/rv_decoder.sv
source/rv_regfile.sv
source/rv_exec.sv
source/rv_core_ctrl.sv
source/rv_retire_counter.sv
source/rv_core_top.sv
tests/rv_core_assert.sv
tests/rv_core_tb.sv

// ==== source/rv_core_ctrl.sv ====
`timescale 1ns/1ps

module rv_core_ctrl (
  input  logic              clk,
  input  logic              reset,
  input  rv_core_pkg::dec_t dec,
  output logic              retire,
  output logic              halted,
  output logic              trap
);

  rv_core_pkg::core_state_e state;
  rv_core_pkg::core_state_e state_next;

  always_comb begin
    state_next = state;
    case (state)
      rv_core_pkg::st_start: begin
        state_next = rv_core_pkg::st_run;
      end
      rv_core_pkg::st_run: begin
        // illegal wins, ebreak is never flagged illegal anyway
        if (dec.illegal) begin
          state_next = rv_core_pkg::st_trap;
        end else if (dec.ebreak) begin
          state_next = rv_core_pkg::st_halt;
        end
      end
      // halt and trap hold until reset
      default: begin
        state_next = state;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= rv_core_pkg::st_start;
    end else begin
      state <= state_next;
    end
  end

  // ebreak retires too
  assign retire = (state == rv_core_pkg::st_run) && !dec.illegal;
  assign halted = (state == rv_core_pkg::st_halt);
  assign trap = (state == rv_core_pkg::st_trap);

endmodule

// ==== source/rv_core_pkg.sv ====
package rv_core_pkg;

  // core widths
  localparam int xlen = 64;
  localparam int ilen = 32;
  localparam int reg_aw = 5;
  localparam int nreg = 32;

  // first fetch address after reset
  localparam logic [ilen-1:0] reset_pc = 32'h8000_0000;
  localparam logic [ilen-1:0] pc_step = 32'd4;

  // system encoding of ebreak in the I immediate
  localparam logic [11:0] ebreak_imm = 12'h001;

  // major opcodes the decoder understands
  typedef enum logic [6:0] {
    op_imm    = 7'b0010011,
    op_auipc  = 7'b0010111,
    op_lui    = 7'b0110111,
    op_jal    = 7'b1101111,
    op_jalr   = 7'b1100111,
    op_system = 7'b1110011
  } opcode_e;

  // 8-bit operation code, add is the only real one for now
  typedef enum logic [7:0] {
    alu_none = 8'h00,
    alu_add  = 8'h01
  } alu_op_e;

  typedef enum logic [1:0] {
    st_start = 2'd0,
    st_run   = 2'd1,
    st_halt  = 2'd2,
    st_trap  = 2'd3
  } core_state_e;

  // everything the rest of the core needs from one decoded word
  typedef struct packed {
    alu_op_e           alu_op;
    logic [xlen-1:0]   op1;
    logic [xlen-1:0]   op2;
    logic              jump;
    logic [ilen-1:0]   jump_base;
    logic [ilen-1:0]   jump_offset;
    logic              rs1_en;
    logic [reg_aw-1:0] rs1_addr;
    logic              rd_en;
    logic [reg_aw-1:0] rd_addr;
    logic              ebreak;
    logic              illegal;
  } dec_t;

endpackage

// ==== source/rv_core_top.sv ====
`timescale 1ns/1ps

module rv_core_top (
  input  logic                           clk,
  input  logic                           reset,
  input  logic [rv_core_pkg::ilen-1:0]   inst,
  output logic [rv_core_pkg::ilen-1:0]   pc,
  output logic                           wb_en,
  output logic [rv_core_pkg::reg_aw-1:0] wb_addr,
  output logic [rv_core_pkg::xlen-1:0]   wb_data,
  output logic [rv_core_pkg::xlen-1:0]   retired,
  output logic                           halted,
  output logic                           trap
);

  rv_core_pkg::dec_t dec;
  logic [rv_core_pkg::reg_aw-1:0] rs1_addr;
  logic [rv_core_pkg::xlen-1:0] rs1_data;
  logic [rv_core_pkg::xlen-1:0] result;
  logic retire;

  rv_decoder u_decoder (
    .inst     (inst),
    .pc       (pc),
    .rs1_data (rs1_data),
    .rs1_addr (rs1_addr),
    .dec      (dec)
  );

  // write only on a retiring word that has a destination
  rv_regfile u_regfile (
    .clk      (clk),
    .reset    (reset),
    .rs1_addr (rs1_addr),
    .rs1_data (rs1_data),
    .we       (retire & dec.rd_en),
    .rd_addr  (dec.rd_addr),
    .rd_data  (result),
    .wb_en    (wb_en),
    .wb_addr  (wb_addr),
    .wb_data  (wb_data)
  );

  rv_exec u_exec (
    .clk    (clk),
    .reset  (reset),
    .retire (retire),
    .dec    (dec),
    .pc     (pc),
    .result (result)
  );

  rv_core_ctrl u_ctrl (
    .clk    (clk),
    .reset  (reset),
    .dec    (dec),
    .retire (retire),
    .halted (halted),
    .trap   (trap)
  );

  rv_retire_counter u_retire_counter (
    .clk    (clk),
    .reset  (reset),
    .retire (retire),
    .count  (retired)
  );

endmodule

// ==== source/rv_decoder.sv ====
`timescale 1ns/1ps

module rv_decoder (
  input  logic [rv_core_pkg::ilen-1:0]   inst,
  input  logic [rv_core_pkg::ilen-1:0]   pc,
  input  logic [rv_core_pkg::xlen-1:0]   rs1_data,
  output logic [rv_core_pkg::reg_aw-1:0] rs1_addr,
  output rv_core_pkg::dec_t              dec
);

  rv_core_pkg::opcode_e opcode;
  logic [2:0] func3;
  logic [rv_core_pkg::reg_aw-1:0] rd;
  logic [rv_core_pkg::reg_aw-1:0] rs1;
  logic [11:0] imm_i;

  logic [rv_core_pkg::xlen-1:0] src_i;
  logic [rv_core_pkg::xlen-1:0] src_u;
  logic [rv_core_pkg::ilen-1:0] src_j;
  logic [rv_core_pkg::xlen-1:0] pc_ext;

  // instruction fields
  assign opcode = rv_core_pkg::opcode_e'(inst[6:0]);
  assign rd = inst[11:7];
  assign func3 = inst[14:12];
  assign rs1 = inst[19:15];
  assign imm_i = inst[31:20];

  // sign extended immediates
  assign src_i = {{52{imm_i[11]}}, imm_i};
  assign src_u = {{32{inst[31]}}, inst[31:12], 12'b0};
  // J offset is scrambled in the word, bit 0 always zero
  assign src_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

  assign pc_ext = {32'b0, pc};

  always_comb begin
    dec = '0;
    dec.alu_op = rv_core_pkg::alu_none;

    case (opcode)
      rv_core_pkg::op_imm: begin
        // only addi for now
        if (func3 == 3'b000) begin
          dec.alu_op = rv_core_pkg::alu_add;
          dec.rs1_en = 1'b1;
          dec.rs1_addr = rs1;
          dec.rd_en = 1'b1;
          dec.rd_addr = rd;
          dec.op1 = rs1_data;
          dec.op2 = src_i;
        end else begin
          dec.illegal = 1'b1;
        end
      end
      rv_core_pkg::op_auipc: begin
        dec.alu_op = rv_core_pkg::alu_add;
        dec.rd_en = 1'b1;
        dec.rd_addr = rd;
        dec.op1 = pc_ext;
        dec.op2 = src_u;
      end
      rv_core_pkg::op_lui: begin
        dec.alu_op = rv_core_pkg::alu_add;
        dec.rd_en = 1'b1;
        dec.rd_addr = rd;
        dec.op2 = src_u;
      end
      rv_core_pkg::op_jal: begin
        // link value is pc + 4
        dec.alu_op = rv_core_pkg::alu_add;
        dec.rd_en = 1'b1;
        dec.rd_addr = rd;
        dec.op1 = pc_ext;
        dec.op2 = {32'b0, rv_core_pkg::pc_step};
        dec.jump = 1'b1;
        dec.jump_base = pc;
        dec.jump_offset = src_j;
      end
      rv_core_pkg::op_jalr: begin
        if (func3 == 3'b000) begin
          dec.alu_op = rv_core_pkg::alu_add;
          dec.rs1_en = 1'b1;
          dec.rs1_addr = rs1;
          dec.rd_en = 1'b1;
          dec.rd_addr = rd;
          dec.op1 = pc_ext;
          dec.op2 = {32'b0, rv_core_pkg::pc_step};
          dec.jump = 1'b1;
          dec.jump_base = rs1_data[rv_core_pkg::ilen-1:0];
          dec.jump_offset = src_i[rv_core_pkg::ilen-1:0];
        end else begin
          dec.illegal = 1'b1;
        end
      end
      rv_core_pkg::op_system: begin
        if (func3 == 3'b000 && imm_i == rv_core_pkg::ebreak_imm) begin
          dec.ebreak = 1'b1;
        end else begin
          dec.illegal = 1'b1;
        end
      end
      default: begin
        dec.illegal = 1'b1;
      end
    endcase
  end

  // read port only addressed when the word reads rs1
  assign rs1_addr = dec.rs1_en ? dec.rs1_addr : '0;

endmodule

// ==== source/rv_exec.sv ====
`timescale 1ns/1ps

module rv_exec (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         retire,
  input  rv_core_pkg::dec_t            dec,
  output logic [rv_core_pkg::ilen-1:0] pc,
  output logic [rv_core_pkg::xlen-1:0] result
);

  logic [rv_core_pkg::ilen-1:0] pc_plus4;
  logic [rv_core_pkg::ilen-1:0] jump_target;
  logic [rv_core_pkg::ilen-1:0] pc_next;

  // writeback value
  always_comb begin
    case (dec.alu_op)
      rv_core_pkg::alu_add: result = dec.op1 + dec.op2;
      default:              result = '0;
    endcase
  end

  assign pc_plus4 = pc + rv_core_pkg::pc_step;

  // jalr needs bit 0 cleared, jal target is already even
  assign jump_target = (dec.jump_base + dec.jump_offset) & ~32'h1;

  assign pc_next = dec.jump ? jump_target : pc_plus4;

  // pc only moves when an instruction retires
  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= rv_core_pkg::reset_pc;
    end else if (retire) begin
      pc <= pc_next;
    end
  end

endmodule

// ==== source/rv_regfile.sv ====
`timescale 1ns/1ps

module rv_regfile (
  input  logic                           clk,
  input  logic                           reset,
  input  logic [rv_core_pkg::reg_aw-1:0] rs1_addr,
  output logic [rv_core_pkg::xlen-1:0]   rs1_data,
  input  logic                           we,
  input  logic [rv_core_pkg::reg_aw-1:0] rd_addr,
  input  logic [rv_core_pkg::xlen-1:0]   rd_data,
  output logic                           wb_en,
  output logic [rv_core_pkg::reg_aw-1:0] wb_addr,
  output logic [rv_core_pkg::xlen-1:0]   wb_data
);

  logic [rv_core_pkg::xlen-1:0] regs [rv_core_pkg::nreg];

  // x0 never takes a write
  assign wb_en = we && (rd_addr != '0);
  assign wb_addr = rd_addr;
  assign wb_data = rd_data;

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < rv_core_pkg::nreg; i++) begin
        regs[i] <= '0;
      end
    end else if (wb_en) begin
      regs[rd_addr] <= rd_data;
    end
  end

  // x0 reads zero
  assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];

endmodule

// ==== source/rv_retire_counter.sv ====
`timescale 1ns/1ps

module rv_retire_counter (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         retire,
  output logic [rv_core_pkg::xlen-1:0] count
);

  // instret, one per retired instruction
  always_ff @(posedge clk) begin
    if (reset) begin
      count <= '0;
    end else if (retire) begin
      count <= count + 1'b1;
    end
  end

endmodule

// ==== tests/rv_core_assert.sv ====
`timescale 1ns/1ps

module rv_core_assert (
  input logic                         clk,
  input logic                         reset,
  input logic [rv_core_pkg::ilen-1:0] pc,
  input logic                         wb_en,
  input logic [rv_core_pkg::xlen-1:0] retired,
  input logic                         halted,
  input logic                         trap
);

  int error_count = 0;

  // every register write belongs to a counted retirement
  wb_counts_retire: assert property (@(posedge clk) disable iff (reset)
    wb_en |=> (retired == $past(retired) + 64'd1))
    else begin
      $error("register write not followed by a retirement count");
      error_count++;
    end

  // a stopped core keeps its pc and instret
  stopped_stable: assert property (@(posedge clk) disable iff (reset)
    (halted || trap) |=> ($stable(pc) && $stable(retired)))
    else begin
      $error("pc or retired moved while the core was stopped");
      error_count++;
    end

  // ebreak retires on its way into halt
  halt_counts_ebreak: assert property (@(posedge clk) disable iff (reset)
    $rose(halted) |-> (retired == $past(retired) + 64'd1))
    else begin
      $error("ebreak not counted when the core halted");
      error_count++;
    end

  // the illegal word is not counted
  trap_not_counted: assert property (@(posedge clk) disable iff (reset)
    $rose(trap) |-> (retired == $past(retired)))
    else begin
      $error("illegal word counted when the core trapped");
      error_count++;
    end

endmodule

bind rv_core_top rv_core_assert u_core_assert (
  .clk     (clk),
  .reset   (reset),
  .pc      (pc),
  .wb_en   (wb_en),
  .retired (retired),
  .halted  (halted),
  .trap    (trap)
);

// ==== tests/rv_core_tb.sv ====
`timescale 1ns/1ps

module rv_core_tb;

  logic clk;
  logic reset;
  logic [31:0] inst;
  logic [31:0] pc;
  logic wb_en;
  logic [4:0] wb_addr;
  logic [63:0] wb_data;
  logic [63:0] retired;
  logic halted;
  logic trap;

  // instruction memory, one word per 4 bytes from reset_pc
  logic [31:0] imem [64];
  int mem_epoch;
  int limit_cycles;
  int fail_count;

  // parsed test data, one entry per line
  logic [31:0] m_addr[$];
  logic [31:0] m_word[$];
  int m_sect[$];
  logic [31:0] e_pc[$];
  logic e_wben[$];
  logic [4:0] e_addr[$];
  logic [63:0] e_data[$];
  int e_sect[$];
  int f_mode[$];
  logic [31:0] f_pc[$];
  logic [63:0] f_count[$];

  rv_core_top dut0 (
    .clk     (clk),
    .reset   (reset),
    .inst    (inst),
    .pc      (pc),
    .wb_en   (wb_en),
    .wb_addr (wb_addr),
    .wb_data (wb_data),
    .retired (retired),
    .halted  (halted),
    .trap    (trap)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Simulation failed");
    $fatal(1, "run stopped");
  endtask

  task automatic check_value(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
    if (actual !== expected) begin
      fail_count++;
      $display("[FAIL] time=%0t signal=%s actual=%h expected=%h",
               $time, name, actual, expected);
      abort_run("value mismatch");
    end
  endtask

  // opcode field zero keeps stray fetches illegal
  function automatic logic [31:0] fill_word(input logic [31:0] addr);
    return {addr[31:7] ^ addr[24:0], 7'b0};
  endfunction

  function automatic logic [31:0] fetch_word(input logic [31:0] addr);
    logic [31:0] idx;
    idx = (addr - rv_core_pkg::reset_pc) >> 2;
    if (idx < $size(imem)) begin
      return imem[idx];
    end
    return fill_word(addr);
  endfunction

  // same cycle fetch, no handshake
  always @(pc or mem_epoch) begin
    inst = fetch_word(pc);
  end

  task automatic read_testdata();
    int fd;
    int code;
    logic [7:0] tag;
    logic [63:0] a, b, c, d;
    logic [8*128-1:0] line;
    fd = $fopen("tests/rv_core_testdata.txt", "r");
    if (fd == 0) begin
      abort_run("cannot open tests/rv_core_testdata.txt");
    end
    code = $fscanf(fd, " %c", tag);
    while (code == 1) begin
      case (tag)
        "M": begin
          code = $fscanf(fd, "%h %h", a, b);
          m_addr.push_back(a[31:0]);
          m_word.push_back(b[31:0]);
          m_sect.push_back(f_mode.size());
        end
        "E": begin
          code = $fscanf(fd, "%h %h %h %h", a, b, c, d);
          e_pc.push_back(a[31:0]);
          e_wben.push_back(b[0]);
          e_addr.push_back(c[4:0]);
          e_data.push_back(d);
          e_sect.push_back(f_mode.size());
        end
        "F": begin
          code = $fscanf(fd, "%h %h %h", a, b, c);
          f_mode.push_back(int'(a));
          f_pc.push_back(b[31:0]);
          f_count.push_back(c);
        end
        "#": code = $fgets(line, fd);
        default: abort_run("unknown line tag in test data file");
      endcase
      code = $fscanf(fd, " %c", tag);
    end
    $fclose(fd);
  endtask

  task automatic load_section(input int s);
    logic [31:0] idx;
    for (int i = 0; i < $size(imem); i++) begin
      imem[i] = fill_word(rv_core_pkg::reset_pc + 32'(4 * i));
    end
    for (int k = 0; k < m_addr.size(); k++) begin
      if (m_sect[k] == s) begin
        idx = (m_addr[k] - rv_core_pkg::reset_pc) >> 2;
        if (idx >= $size(imem)) begin
          abort_run("program word outside instruction memory");
        end
        imem[idx] = m_word[k];
      end
    end
    mem_epoch++;
  endtask

  task automatic run_section(input int s);
    logic [63:0] count;
    int stop_wait;
    count = 0;
    stop_wait = 0;
    load_section(s);
    reset <= 1'b1;
    @(posedge clk);
    @(negedge clk);
    // core held in reset
    check_value("wb_en", wb_en, 0);
    check_value("halted", halted, 0);
    check_value("trap", trap, 0);
    check_value("retired", retired, 0);
    @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    // start cycle, nothing retires yet
    check_value("pc", pc, rv_core_pkg::reset_pc);
    check_value("wb_en", wb_en, 0);
    check_value("retired", retired, 0);
    @(posedge clk);
    for (int k = 0; k < e_pc.size(); k++) begin
      if (e_sect[k] == s) begin
        @(negedge clk);
        check_value("halted", halted, 0);
        check_value("trap", trap, 0);
        check_value("pc", pc, e_pc[k]);
        check_value("retired", retired, count);
        check_value("wb_en", wb_en, e_wben[k]);
        if (e_wben[k]) begin
          check_value("wb_addr", wb_addr, e_addr[k]);
          check_value("wb_data", wb_data, e_data[k]);
        end
        count++;
        @(posedge clk);
      end
    end
    @(negedge clk);
    while (!halted && !trap) begin
      // illegal word sits in run for one cycle without retiring
      check_value("wb_en", wb_en, 0);
      check_value("pc", pc, f_pc[s]);
      stop_wait++;
      if (stop_wait > 2) begin
        abort_run("core did not halt or trap after the last expected retirement");
      end
      @(negedge clk);
    end
    repeat (3) begin
      check_value("halted", halted, f_mode[s] == 0);
      check_value("trap", trap, f_mode[s] == 1);
      check_value("pc", pc, f_pc[s]);
      check_value("retired", retired, f_count[s]);
      check_value("wb_en", wb_en, 0);
      @(negedge clk);
    end
    @(posedge clk);
  endtask

  // watchdog sized from the number of expected retirements
  initial begin
    wait (limit_cycles > 0);
    repeat (limit_cycles) @(posedge clk);
    abort_run($sformatf("timeout, no result after %0d clock cycles", limit_cycles));
  end

  initial begin
    reset = 1'b1;
    inst = '0;
    read_testdata();
    if (f_mode.size() == 0) begin
      abort_run("test data file holds no program section");
    end
    limit_cycles = e_pc.size() + 10 * (f_mode.size() + 1);
    for (int s = 0; s < f_mode.size(); s++) begin
      run_section(s);
    end
    if (fail_count == 0 && dut0.u_core_assert.error_count == 0) begin
      $display("Simulation completed successfully");
      $finish;
    end else begin
      $display("Simulation failed");
      $fatal(1, "checks failed");
    end
  end

endmodule

// ==== tests/rv_core_testdata.txt ====
# M <addr> <word> | E <pc> <wb_en> <wb_addr> <wb_data> | F <0 halt or 1 trap> <pc> <retired>
# all fields hex, an F line closes each program section
M 80000000 fffff0b7
M 80000004 fff08113
M 80000008 7ff00193
M 8000000c 00518013
M 80000010 12345217
M 80000014 ff020293
M 80000018 00c0036f
M 80000024 021303e7
M 8000003c 00838413
M 80000040 00100073
E 80000000 1 01 fffffffffffff000
E 80000004 1 02 ffffffffffffefff
E 80000008 1 03 00000000000007ff
E 8000000c 0 00 0000000000000000
E 80000010 1 04 0000000092345010
E 80000014 1 05 0000000092345000
E 80000018 1 06 000000008000001c
E 80000024 1 07 0000000080000028
E 8000003c 1 08 0000000080000030
E 80000040 0 00 0000000000000000
F 0 80000044 a
M 80000000 00500093
M 80000004 ffd08113
M 80000008 00000033
E 80000000 1 01 0000000000000005
E 80000004 1 02 0000000000000002
F 1 80000008 2
